// File: all.f
inverter_pkg.sv
spi_link_if.sv
spi_master.sv
uart_tx.sv
module_dispatcher.sv
inverter_top.sv
tb_clock_gen.sv
inverter_sva.sv
inverter_tb.sv

// File: Makefile
# Verilator flow for the gate-drive controller testbench
# Override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= inverter_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?=

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Exit status of the simulator is the pass or fail result
sim: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// File: inverter_tb.sv
/* Testbench for the gate-drive controller: SPI slave models feed table words,
   per-module UART decoders check bytes, parity, stop bits and shoot coverage. */
`timescale 1ns/1ps

module inverter_tb import inverter_pkg::*; ();

    typedef struct packed {
        logic      link2;
        logic      kept;
        logic      rnd;
        spi_word_t word;
    } stim_row_t;

    localparam int NUM_ROWS = 12;
    localparam int SPI_WORD_CYCLES = 2 + SPI_WORD_BITS * 2 * SPI_HALF_PERIOD;
    localparam int FRAME_CYCLES = 11 * BAUD_DIV;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * (SPI_WORD_CYCLES + FRAME_CYCLES) * 2
                                    + STARTUP_CYCLES;
    localparam int QUIET_CYCLES = 2 * (SPI_WORD_CYCLES + FRAME_CYCLES);

    // Link 1 feeds modules 0 and 2, link 2 feeds module 1
    // Columns: link2, kept, random duty, {id, duty}
    localparam stim_row_t STIM [NUM_ROWS] = '{
        '{1'b0, 1'b1, 1'b0, 16'h003A},
        '{1'b1, 1'b1, 1'b0, 16'h01C5},
        '{1'b0, 1'b1, 1'b0, 16'h027E},
        '{1'b1, 1'b1, 1'b0, 16'h0104},
        '{1'b0, 1'b1, 1'b0, 16'h00FF},
        '{1'b1, 1'b0, 1'b0, 16'h0599},
        '{1'b0, 1'b1, 1'b1, 16'h0200},
        '{1'b1, 1'b1, 1'b1, 16'h0100},
        '{1'b0, 1'b0, 1'b0, 16'h0955},
        '{1'b0, 1'b1, 1'b1, 16'h0000},
        '{1'b1, 1'b1, 1'b0, 16'h0180},
        '{1'b0, 1'b1, 1'b0, 16'h0201}
    };

    logic         clk;
    logic         rst;
    logic         spi_sclk_1;
    logic         spi_cs_n_1;
    logic         spi_miso_1 = 1'b0;
    logic         spi_sclk_2;
    logic         spi_cs_n_2;
    logic         spi_miso_2 = 1'b0;
    module_mask_t uart_txd;
    logic         shoot;

    int           seed = 54;
    spi_word_t    link_words [2][NUM_ROWS];
    int           link_len [2] = '{0, 0};
    int           link_ptr [2] = '{0, 0};
    int           cs_falls [2] = '{0, 0};
    logic         prev_cs [2] = '{1'b1, 1'b1};
    logic         prev_sclk [2] = '{1'b0, 1'b0};
    spi_word_t    cur_word [2];
    int           bit_idx [2] = '{0, 0};
    duty_t        exp_duty [NUM_MODULES][NUM_ROWS];
    int           exp_len [NUM_MODULES];
    int           rx_ptr [NUM_MODULES];
    logic         rx_active [NUM_MODULES];
    int           rx_cnt [NUM_MODULES];
    duty_t        rx_data [NUM_MODULES];
    logic         rx_par [NUM_MODULES];
    module_mask_t seen_mask = '0;
    int           shoot_count = 0;
    int           after_rst = 0;
    int           cycle_cnt = 0;
    logic         rst_at_edge;
    logic         miso_bit;

    tb_clock_gen i_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    inverter_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .spi_sclk_1 (spi_sclk_1),
        .spi_cs_n_1 (spi_cs_n_1),
        .spi_miso_1 (spi_miso_1),
        .spi_sclk_2 (spi_sclk_2),
        .spi_cs_n_2 (spi_cs_n_2),
        .spi_miso_2 (spi_miso_2),
        .uart_txd   (uart_txd),
        .shoot      (shoot)
    );

    task automatic fail_run();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_duty(input string name, input duty_t exp, input duty_t act);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %02h, got %02h", $time, name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_parity(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_shoot(input string name, input module_mask_t exp,
                               input module_mask_t act);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
            fail_run();
        end
    endtask

    // SPI slave: next word on falling cs_n, next bit on falling sclk
    task automatic serve_link(input int l, input logic cs, input logic sck, output logic miso);
        if (prev_cs[l] && !cs) begin
            if (after_rst <= STARTUP_CYCLES) begin
                $display("Link %0d selected during the start-up hold-off", l + 1);
                fail_run();
            end
            cs_falls[l]++;
            if (link_ptr[l] < link_len[l]) begin
                cur_word[l] = link_words[l][link_ptr[l]];
                link_ptr[l]++;
            end else begin
                cur_word[l] = {8'hFF, 8'h00};
            end
            bit_idx[l] = SPI_WORD_BITS - 1;
        end else if (!cs && prev_sclk[l] && !sck && bit_idx[l] > 0) begin
            bit_idx[l]--;
        end
        prev_cs[l] = cs;
        prev_sclk[l] = sck;
        miso = cur_word[l][bit_idx[l]];
    endtask

    // Mid-bit sampling, bit k sits at k * BAUD_DIV + BAUD_DIV / 2
    task automatic decode_uart(input int m, input logic line);
        int k;
        string name;
        name = $sformatf("uart_txd[%0d]", m);
        if (!rx_active[m]) begin
            if (!line) begin
                rx_active[m] = 1'b1;
                rx_cnt[m] = 0;
                seen_mask[m] = 1'b1;
            end
        end else begin
            rx_cnt[m]++;
            if (rx_cnt[m] % BAUD_DIV == BAUD_DIV / 2) begin
                k = rx_cnt[m] / BAUD_DIV;
                if (k == 0) begin
                    check_level({name, " start bit"}, 1'b0, line);
                end else if (k <= 8) begin
                    rx_data[m][k-1] = line;
                end else if (k == 9) begin
                    rx_par[m] = line;
                end else begin
                    check_parity({name, " parity"}, ^rx_data[m], rx_par[m]);
                    check_level({name, " stop bit"}, 1'b1, line);
                    if (rx_ptr[m] >= exp_len[m]) begin
                        $display("Module %0d sent a byte that no table word asked for", m);
                        fail_run();
                    end
                    check_duty({name, " duty"}, exp_duty[m][rx_ptr[m]], rx_data[m]);
                    rx_ptr[m]++;
                    rx_active[m] = 1'b0;
                end
            end
        end
    endtask

    function automatic logic all_received();
        logic done;
        done = 1'b1;
        for (int m = 0; m < NUM_MODULES; m++) begin
            if (rx_ptr[m] < exp_len[m]) begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    always begin
        @(posedge clk);
        rst_at_edge = rst;
        #1;
        if (rst_at_edge) begin
            check_level("spi_cs_n_1", 1'b1, spi_cs_n_1);
            check_level("spi_cs_n_2", 1'b1, spi_cs_n_2);
            check_level("shoot", 1'b0, shoot);
            for (int m = 0; m < NUM_MODULES; m++) begin
                check_level($sformatf("uart_txd[%0d]", m), 1'b1, uart_txd[m]);
            end
        end else begin
            after_rst++;
            serve_link(0, spi_cs_n_1, spi_sclk_1, miso_bit);
            spi_miso_1 = miso_bit;
            serve_link(1, spi_cs_n_2, spi_sclk_2, miso_bit);
            spi_miso_2 = miso_bit;
            for (int m = 0; m < NUM_MODULES; m++) begin
                decode_uart(m, uart_txd[m]);
            end
            if (shoot) begin
                shoot_count++;
                check_shoot("shoot module coverage", '1, seen_mask);
                seen_mask = '0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, not every duty byte arrived", cycle_cnt);
            fail_run();
        end
    end

    initial begin
        stim_row_t row;
        int l;
        int id;
        for (int m = 0; m < NUM_MODULES; m++) begin
            exp_len[m] = 0;
            rx_ptr[m] = 0;
            rx_active[m] = 1'b0;
            rx_cnt[m] = 0;
        end
        // Split the table into per-link words and per-module expected bytes
        for (int r = 0; r < NUM_ROWS; r++) begin
            row = STIM[r];
            if (row.rnd) begin
                row.word.duty = duty_t'($random(seed));
            end
            l = row.link2 ? 1 : 0;
            link_words[l][link_len[l]] = row.word;
            link_len[l]++;
            if (row.kept) begin
                id = int'(row.word.id);
                exp_duty[id][exp_len[id]] = row.word.duty;
                exp_len[id]++;
            end
        end
        while (!all_received()) begin
            @(posedge clk);
        end
        // Quiet window so that a stray frame would still show up
        repeat (QUIET_CYCLES) @(posedge clk);
        if (shoot_count > 0 && cs_falls[0] > link_len[0] && cs_falls[1] > link_len[1]) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Missing activity: %0d shoots, link polls %0d and %0d",
                     shoot_count, cs_falls[0], cs_falls[1]);
            fail_run();
        end
    end

endmodule

// File: inverter_sva.sv
/* Pin-level assertions for the controller top level, attached by bind */
`timescale 1ns/1ps

module inverter_sva import inverter_pkg::*; (
    input logic         clk,
    input logic         rst,
    input logic         spi_sclk_1,
    input logic         spi_cs_n_1,
    input logic         spi_sclk_2,
    input logic         spi_cs_n_2,
    input module_mask_t uart_txd,
    input logic         shoot
);

    // Shoot is a single-cycle pulse
    a_shoot_single: assert property (@(posedge clk) disable iff (rst) shoot |=> !shoot)
        else $error("shoot high for two cycles");

    // SCLK moves only inside a frame
    a_sclk_1: assert property (@(posedge clk) disable iff (rst)
        (spi_sclk_1 != $past(spi_sclk_1)) |-> !spi_cs_n_1)
        else $error("spi_sclk_1 toggled with spi_cs_n_1 high");

    a_sclk_2: assert property (@(posedge clk) disable iff (rst)
        (spi_sclk_2 != $past(spi_sclk_2)) |-> !spi_cs_n_2)
        else $error("spi_sclk_2 toggled with spi_cs_n_2 high");

    a_txd_reset: assert property (@(posedge clk) (rst && $past(rst)) |-> (uart_txd == '1))
        else $error("uart_txd not idle during reset");

endmodule

bind inverter_top inverter_sva i_sva (
    .clk        (clk),
    .rst        (rst),
    .spi_sclk_1 (spi_sclk_1),
    .spi_cs_n_1 (spi_cs_n_1),
    .spi_sclk_2 (spi_sclk_2),
    .spi_cs_n_2 (spi_cs_n_2),
    .uart_txd   (uart_txd),
    .shoot      (shoot)
);

// File: tb_clock_gen.sv
/* Testbench clock (4 ns period) and reset held high for two clock cycles */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial clk = 1'b0;

    always #2 clk = ~clk;

    // Released just after the second rising edge
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// File: inverter_top.sv
/* Gate-drive controller top level: two SPI command links, the dispatcher
   and one UART transmitter per power module, wired to the board pins. */
`timescale 1ns/1ps

module inverter_top import inverter_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    output logic         spi_sclk_1,
    output logic         spi_cs_n_1,
    input  logic         spi_miso_1,
    output logic         spi_sclk_2,
    output logic         spi_cs_n_2,
    input  logic         spi_miso_2,
    output module_mask_t uart_txd,
    output logic         shoot
);

    spi_link_if link_1 ();
    spi_link_if link_2 ();

    module_mask_t tx_start;
    module_mask_t tx_busy;
    duty_t        tx_data [NUM_MODULES];

    spi_master i_spi_1 (
        .clk  (clk),
        .rst  (rst),
        .link (link_1),
        .sclk (spi_sclk_1),
        .cs_n (spi_cs_n_1),
        .miso (spi_miso_1)
    );

    spi_master i_spi_2 (
        .clk  (clk),
        .rst  (rst),
        .link (link_2),
        .sclk (spi_sclk_2),
        .cs_n (spi_cs_n_2),
        .miso (spi_miso_2)
    );

    module_dispatcher i_dispatcher (
        .clk      (clk),
        .rst      (rst),
        .link_1   (link_1),
        .link_2   (link_2),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_busy  (tx_busy),
        .shoot    (shoot)
    );

    // One transmitter per power module
    for (genvar g = 0; g < NUM_MODULES; g++) begin : g_uart
        uart_tx i_uart_tx (
            .clk   (clk),
            .rst   (rst),
            .start (tx_start[g]),
            .data  (tx_data[g]),
            .txd   (uart_txd[g]),
            .busy  (tx_busy[g])
        );
    end

endmodule

// File: module_dispatcher.sv
/* Polls both SPI links, keeps one pending word per link and routes duty bytes
   to the addressed module's UART; fires shoot once every module has a byte. */
`timescale 1ns/1ps

module module_dispatcher import inverter_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    spi_link_if.master        link_1,
    spi_link_if.master        link_2,
    output module_mask_t      tx_start,
    output duty_t             tx_data [NUM_MODULES],
    input  module_mask_t      tx_busy,
    output logic              shoot
);

    logic [STARTUP_CNT_W-1:0] startup_cnt;
    logic                     running;
    logic [1:0]               link_busy;
    logic [1:0]               link_done;
    logic [1:0]               link_start;
    spi_word_t                link_word [2];
    spi_word_t                pend_word [2];
    logic [1:0]               pend_valid;
    logic [MOD_IDX_W-1:0]     pend_idx [2];
    logic [1:0]               id_ok;
    logic [1:0]               can_go;
    logic                     sel;
    logic                     go;
    module_mask_t             set_bit;
    module_mask_t             sent_mask;
    logic                     fire;

    assign link_busy = {link_2.busy, link_1.busy};
    assign link_done = {link_2.done, link_1.done};
    assign link_word[0] = link_1.rx_word;
    assign link_word[1] = link_2.rx_word;
    assign link_1.start = link_start[0];
    assign link_2.start = link_start[1];

    assign running = (startup_cnt == STARTUP_CNT_W'(STARTUP_CYCLES));

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            pend_idx[i] = pend_word[i].id[MOD_IDX_W-1:0];
            id_ok[i] = (pend_word[i].id < module_id_t'(NUM_MODULES));
            // Bad ids leave at once, good ones wait for an idle UART
            can_go[i] = pend_valid[i] &&
                        (!id_ok[i] || !(tx_busy[pend_idx[i]] || tx_start[pend_idx[i]]));
        end
        // Link 1 has priority
        sel = !can_go[0];
        go = |can_go;
        set_bit = '0;
        if (go && id_ok[sel]) begin
            set_bit[pend_idx[sel]] = 1'b1;
        end
    end

    assign fire = (&sent_mask) && !(|(tx_busy | tx_start));

    always_ff @(posedge clk) begin
        if (rst) begin
            startup_cnt <= '0;
            link_start  <= '0;
            pend_valid  <= '0;
            tx_start    <= '0;
            sent_mask   <= '0;
            shoot       <= 1'b0;
        end else begin
            if (!running) begin
                startup_cnt <= startup_cnt + 1'b1;
            end
            for (int i = 0; i < 2; i++) begin
                link_start[i] <= running && !pend_valid[i] && !link_busy[i] &&
                                 !link_done[i] && !link_start[i];
                if (link_done[i]) begin
                    pend_valid[i] <= 1'b1;
                end else if (go && sel == 1'(i)) begin
                    pend_valid[i] <= 1'b0;
                end
            end
            tx_start  <= set_bit;
            shoot     <= fire;
            sent_mask <= (fire ? '0 : sent_mask) | set_bit;
        end
    end

    // Pending words and UART payload
    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (link_done[i]) begin
                pend_word[i] <= link_word[i];
            end
        end
        for (int m = 0; m < NUM_MODULES; m++) begin
            if (set_bit[m]) begin
                tx_data[m] <= pend_word[sel].duty;
            end
        end
    end

endmodule

// File: uart_tx.sv
/* UART transmitter for one power module: start bit, 8 data bits LSB first,
   even parity and one stop bit, each BAUD_DIV clk cycles long. */
`timescale 1ns/1ps

module uart_tx import inverter_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    input  duty_t data,
    output logic  txd,
    output logic  busy
);

    logic [BAUD_CNT_W-1:0] baud_cnt;
    logic [3:0]            bit_idx;
    // Data, parity and stop still to go out
    logic [9:0]            frame;
    logic                  bit_end;

    assign bit_end = (baud_cnt == BAUD_CNT_W'(BAUD_DIV - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            txd      <= 1'b1;
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_idx  <= '0;
        end else if (!busy) begin
            if (start) begin
                // Start bit goes out right away
                txd      <= 1'b0;
                busy     <= 1'b1;
                baud_cnt <= '0;
                bit_idx  <= '0;
            end
        end else if (bit_end) begin
            baud_cnt <= '0;
            if (bit_idx == 4'd10) begin
                busy <= 1'b0;
            end else begin
                txd     <= frame[0];
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && start) begin
            frame <= {1'b1, ^data, data};
        end else if (busy && bit_end) begin
            frame <= {1'b1, frame[9:1]};
        end
    end

endmodule

// File: spi_master.sv
/* SPI mode-0 master that reads one 16-bit command word per start strobe.
   MISO is sampled on rising SCLK, MSB first; MOSI is not used. */
`timescale 1ns/1ps

module spi_master import inverter_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    spi_link_if.link   link,
    output logic       sclk,
    output logic       cs_n,
    input  logic       miso
);

    logic [HALF_CNT_W-1:0]    half_cnt;
    logic [BIT_CNT_W-1:0]     bit_cnt;
    logic [SPI_WORD_BITS-1:0] shift_q;
    logic                     edge_due;
    logic                     last_done;
    logic                     sample_now;

    assign edge_due = (half_cnt == HALF_CNT_W'(SPI_HALF_PERIOD - 1));
    // All 16 falling edges seen, close the frame
    assign last_done = (bit_cnt == BIT_CNT_W'(SPI_WORD_BITS));
    assign sample_now = link.busy && !last_done && edge_due && !sclk;

    always_ff @(posedge clk) begin
        if (rst) begin
            link.busy <= 1'b0;
            link.done <= 1'b0;
            cs_n      <= 1'b1;
            sclk      <= 1'b0;
            half_cnt  <= '0;
            bit_cnt   <= '0;
        end else begin
            link.done <= 1'b0;
            if (!link.busy) begin
                if (link.start) begin
                    link.busy <= 1'b1;
                    cs_n      <= 1'b0;
                    half_cnt  <= '0;
                    bit_cnt   <= '0;
                end
            end else if (last_done) begin
                link.busy <= 1'b0;
                link.done <= 1'b1;
                cs_n      <= 1'b1;
            end else if (edge_due) begin
                half_cnt <= '0;
                sclk     <= ~sclk;
                // Count bits on the falling edge
                if (sclk) begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

    // Shift register and result word
    always_ff @(posedge clk) begin
        if (sample_now) begin
            shift_q <= {shift_q[SPI_WORD_BITS-2:0], miso};
        end
        if (link.busy && last_done) begin
            link.rx_word <= spi_word_t'(shift_q);
        end
    end

endmodule

// File: spi_link_if.sv
/* Start/result handshake between the dispatcher and one SPI master.
   A start seen while busy is high is ignored by the master. */
`timescale 1ns/1ps

interface spi_link_if import inverter_pkg::*; ();

    logic      start;
    logic      busy;
    logic      done;
    // Valid with done, held until the next transfer ends
    spi_word_t rx_word;

    modport master (
        output start,
        input  busy,
        input  done,
        input  rx_word
    );

    modport link (
        input  start,
        output busy,
        output done,
        output rx_word
    );

endinterface

// File: inverter_pkg.sv
/* Shared constants and types for the gate-drive controller.
   Imported by every interface and module of the design. */

package inverter_pkg;

    // Power modules, one UART line each
    localparam int NUM_MODULES = 3;
    localparam int MOD_IDX_W = $clog2(NUM_MODULES);

    // SPI command link
    localparam int SPI_WORD_BITS = 16;
    localparam int SPI_HALF_PERIOD = 2;
    localparam int HALF_CNT_W = $clog2(SPI_HALF_PERIOD + 1);
    localparam int BIT_CNT_W = $clog2(SPI_WORD_BITS + 1);

    // UART bit time in clk cycles
    localparam int BAUD_DIV = 8;
    localparam int BAUD_CNT_W = $clog2(BAUD_DIV);

    // Hold-off before the first SPI poll
    localparam int STARTUP_CYCLES = 50;
    localparam int STARTUP_CNT_W = $clog2(STARTUP_CYCLES + 1);

    typedef logic [7:0] module_id_t;
    typedef logic [7:0] duty_t;

    // Upper byte addresses the module, lower byte is its duty
    typedef struct packed {
        module_id_t id;
        duty_t      duty;
    } spi_word_t;

    typedef logic [NUM_MODULES-1:0] module_mask_t;

endpackage
